//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_audio_dma
RTL_TOP   ?= audio_dma_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+common
common/dma_pkg.sv
src/dma_csr.sv
s2mm/s2mm_packer.sv
s2mm/beat_fifo.sv
s2mm/s2mm_burst_writer.sv
src/audio_dma_top.sv
tb/dma_sva.sv
tb/tb_audio_dma.sv

//--- common/dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

//////////////////////////////
// sensor side
//////////////////////////////

// one sensor word per data-enable
`define DMA_IN_W        64

//////////////////////////////
// memory side
//////////////////////////////

// AXI data beat
`define DMA_AXI_W       256
// sensor words packed into one beat
`define DMA_LANES       4
`define DMA_ADDR_W      32
// beats per AXI write burst
`define DMA_BURST_LEN   4

//////////////////////////////
// buffering and host
//////////////////////////////

// beat buffer entries, also the packer's credit pool
`define DMA_FIFO_DEPTH  8
`define DMA_CSR_W       32

`endif

//--- common/dma_pkg.sv
`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

    //////////////////////////////
    // datapath types
    //////////////////////////////

    typedef logic [`DMA_IN_W-1:0] in_word_t;

    // lane 0 sits in the lowest bits
    typedef logic [`DMA_AXI_W-1:0] beat_t;

    // byte address in memory
    typedef logic [`DMA_ADDR_W-1:0] addr_t;

    // occupancy and credits, must reach the full depth
    typedef logic [$clog2(`DMA_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    //////////////////////////////
    // host registers
    //////////////////////////////

    typedef logic [`DMA_CSR_W-1:0] csr_word_t;
    typedef logic [15:0] burst_cnt_t;

    typedef enum logic [1:0] {
        CSR_CTRL   = 2'd0,
        CSR_BASE   = 2'd1,
        CSR_PAGE   = 2'd2,
        CSR_STATUS = 2'd3
    } csr_idx_e;

    //////////////////////////////
    // AXI encodings
    //////////////////////////////

    // 32 bytes per beat
    localparam logic [2:0] AXI_SIZE_BEAT  = 3'd5;
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

endpackage

`default_nettype wire

//--- s2mm/beat_fifo.sv
`default_nettype none

`include "dma_defines.svh"

module beat_fifo (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_push,
    input  dma_pkg::beat_t     i_beat,
    input  logic               i_pop,
    output dma_pkg::beat_t     o_head,
    output dma_pkg::fifo_cnt_t o_count,
    output logic               o_credit_return
);
    import dma_pkg::*;

    localparam int DEPTH = `DMA_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    beat_t            mem [DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    fifo_cnt_t        r_count;
    logic             r_credit;
    logic             w_pop;

    // credits keep the packer from pushing into a full buffer
    assign w_pop = i_pop && (r_count != '0);

    always_ff @(posedge clk) begin
        if (i_push)
            mem[r_wr_ptr] <= i_beat;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
            r_credit <= 1'b0;
        end else begin
            if (i_push)
                r_wr_ptr <= r_wr_ptr + 1'b1;
            if (w_pop)
                r_rd_ptr <= r_rd_ptr + 1'b1;
            r_count  <= r_count + fifo_cnt_t'(i_push) - fifo_cnt_t'(w_pop);
            // every freed entry goes back to the packer
            r_credit <= w_pop;
        end
    end

    // first word falls through
    assign o_head          = mem[r_rd_ptr];
    assign o_count         = r_count;
    assign o_credit_return = r_credit;

endmodule

`default_nettype wire

//--- s2mm/s2mm_burst_writer.sv
`default_nettype none

`include "dma_defines.svh"

module s2mm_burst_writer (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_enable,
    input  dma_pkg::addr_t          i_base,
    input  dma_pkg::burst_cnt_t     i_page_bursts,
    input  dma_pkg::beat_t          i_head,
    input  dma_pkg::fifo_cnt_t      i_count,
    output logic                    o_pop,
    output logic                    o_page_done,
    // write address
    output dma_pkg::addr_t          o_m_axi_awaddr,
    output logic [7:0]              o_m_axi_awlen,
    output logic [2:0]              o_m_axi_awsize,
    output logic [1:0]              o_m_axi_awburst,
    output logic                    o_m_axi_awvalid,
    input  logic                    i_m_axi_awready,
    // write data
    output dma_pkg::beat_t          o_m_axi_wdata,
    output logic [`DMA_AXI_W/8-1:0] o_m_axi_wstrb,
    output logic                    o_m_axi_wlast,
    output logic                    o_m_axi_wvalid,
    input  logic                    i_m_axi_wready,
    // write response
    input  logic [1:0]              i_m_axi_bresp,
    input  logic                    i_m_axi_bvalid,
    output logic                    o_m_axi_bready
);
    import dma_pkg::*;

    localparam int BEAT_W = $clog2(`DMA_BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DMA_BURST_LEN - 1);
    localparam addr_t BURST_BYTES = addr_t'(`DMA_BURST_LEN * `DMA_AXI_W / 8);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_e;

    state_e            r_state;
    logic [BEAT_W-1:0] r_beat_cnt;
    burst_cnt_t        r_burst_idx;
    addr_t             r_addr;
    logic              w_start;
    logic              w_aw_fire;
    logic              w_w_fire;
    logic              w_b_fire;
    logic              w_page_end;
    logic              w_resp_err;

    // a full burst must already sit in the buffer
    assign w_start    = (r_state == ST_IDLE) && i_enable &&
                        (i_count >= fifo_cnt_t'(`DMA_BURST_LEN));
    assign w_aw_fire  = o_m_axi_awvalid && i_m_axi_awready;
    assign w_w_fire   = o_m_axi_wvalid && i_m_axi_wready;
    assign w_b_fire   = o_m_axi_bready && i_m_axi_bvalid;
    assign w_page_end = r_burst_idx >= (i_page_bursts - burst_cnt_t'(1));
    // SLVERR or DECERR
    assign w_resp_err = i_m_axi_bresp[1];

    // burst k of the page lands at base + k*128
    always_ff @(posedge clk) begin
        if (w_start)
            r_addr <= i_base + addr_t'(r_burst_idx) * BURST_BYTES;
    end

    ////////////////////////////////
    // burst FSM
    ////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state     <= ST_IDLE;
            r_beat_cnt  <= '0;
            r_burst_idx <= '0;
            o_page_done <= 1'b0;
        end else begin
            o_page_done <= 1'b0;
            case (r_state)
                ST_IDLE: begin
                    if (w_start)
                        r_state <= ST_ADDR;
                end
                ST_ADDR: begin
                    if (w_aw_fire) begin
                        r_state    <= ST_DATA;
                        r_beat_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (w_w_fire) begin
                        r_beat_cnt <= r_beat_cnt + 1'b1;
                        if (r_beat_cnt == LAST_BEAT)
                            r_state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (w_b_fire) begin
                        r_state <= ST_IDLE;
                        // failed burst leaves its slot to the next one
                        if (!w_resp_err) begin
                            if (w_page_end) begin
                                r_burst_idx <= '0;
                                o_page_done <= 1'b1;
                            end else begin
                                r_burst_idx <= r_burst_idx + burst_cnt_t'(1);
                            end
                        end
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    assign o_m_axi_awaddr  = r_addr;
    assign o_m_axi_awlen   = 8'(`DMA_BURST_LEN - 1);
    assign o_m_axi_awsize  = AXI_SIZE_BEAT;
    assign o_m_axi_awburst = AXI_BURST_INCR;
    assign o_m_axi_awvalid = (r_state == ST_ADDR);

    assign o_m_axi_wdata   = i_head;
    assign o_m_axi_wstrb   = '1;
    assign o_m_axi_wvalid  = (r_state == ST_DATA);
    assign o_m_axi_wlast   = o_m_axi_wvalid && (r_beat_cnt == LAST_BEAT);

    assign o_m_axi_bready  = (r_state == ST_RESP);
    assign o_pop           = w_w_fire;

endmodule

`default_nettype wire

//--- s2mm/s2mm_packer.sv
`default_nettype none

`include "dma_defines.svh"

module s2mm_packer (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_enable,
    input  logic              i_frame_start,
    input  logic              i_de,
    input  dma_pkg::in_word_t i_data,
    output logic              o_push,
    output dma_pkg::beat_t    o_beat,
    input  logic              i_credit_return,
    output logic              o_overflow
);
    import dma_pkg::*;

    localparam int LANE_W = $clog2(`DMA_LANES);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`DMA_LANES - 1);
    localparam fifo_cnt_t CREDIT_INIT = fifo_cnt_t'(`DMA_FIFO_DEPTH);

    logic [LANE_W-1:0] r_lane;
    logic [LANE_W-1:0] w_lane_sel;
    logic              w_take;
    logic              w_complete;
    logic              w_spend;
    beat_t             r_beat;
    fifo_cnt_t         r_credit;

    assign w_take     = i_enable && i_de;
    // a word arriving with frame start opens the new beat
    assign w_lane_sel = i_frame_start ? '0 : r_lane;
    assign w_complete = w_take && (w_lane_sel == LAST_LANE);
    assign w_spend    = w_complete && (r_credit != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            r_lane <= '0;
        else if (!i_enable)
            r_lane <= '0;
        else if (i_de)
            r_lane <= w_lane_sel + 1'b1;
        else if (i_frame_start)
            r_lane <= '0;
    end

    always_ff @(posedge clk) begin
        if (w_take)
            r_beat[w_lane_sel*`DMA_IN_W +: `DMA_IN_W] <= i_data;
    end

    ////////////////////////////////
    // credits toward the beat buffer
    ////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_credit   <= CREDIT_INIT;
            o_push     <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            r_credit   <= r_credit - fifo_cnt_t'(w_spend) + fifo_cnt_t'(i_credit_return);
            o_push     <= w_spend;
            // no credit left, whole beat is lost
            o_overflow <= w_complete && !w_spend;
        end
    end

    assign o_beat = r_beat;

endmodule

`default_nettype wire

//--- src/audio_dma_top.sv
`default_nettype none

`include "dma_defines.svh"

module audio_dma_top (
    input  logic                    clk,
    input  logic                    i_rst_n,
    // sensor
    input  logic                    i_frame_start,
    input  logic                    i_de,
    input  dma_pkg::in_word_t       i_data,
    // host
    input  logic                    i_csr_we,
    input  dma_pkg::csr_idx_e       i_csr_addr,
    input  dma_pkg::csr_word_t      i_csr_wdata,
    output dma_pkg::csr_word_t      o_csr_rdata,
    output logic                    o_irq,
    // AXI write
    output dma_pkg::addr_t          o_m_axi_awaddr,
    output logic [7:0]              o_m_axi_awlen,
    output logic [2:0]              o_m_axi_awsize,
    output logic [1:0]              o_m_axi_awburst,
    output logic                    o_m_axi_awvalid,
    input  logic                    i_m_axi_awready,
    output dma_pkg::beat_t          o_m_axi_wdata,
    output logic [`DMA_AXI_W/8-1:0] o_m_axi_wstrb,
    output logic                    o_m_axi_wlast,
    output logic                    o_m_axi_wvalid,
    input  logic                    i_m_axi_wready,
    input  logic [1:0]              i_m_axi_bresp,
    input  logic                    i_m_axi_bvalid,
    output logic                    o_m_axi_bready
);
    import dma_pkg::*;

    logic       w_enable;
    addr_t      w_base;
    burst_cnt_t w_page_bursts;
    logic       w_overflow;
    logic       w_page_done;
    logic       w_push;
    beat_t      w_beat;
    logic       w_credit_return;
    logic       w_pop;
    beat_t      w_head;
    fifo_cnt_t  w_count;

    dma_csr u_csr (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_csr_we      (i_csr_we),
        .i_csr_addr    (i_csr_addr),
        .i_csr_wdata   (i_csr_wdata),
        .o_csr_rdata   (o_csr_rdata),
        .o_enable      (w_enable),
        .o_base        (w_base),
        .o_page_bursts (w_page_bursts),
        .i_overflow    (w_overflow),
        .i_page_done   (w_page_done),
        .o_irq         (o_irq)
    );

    // sensor words into beats
    s2mm_packer u_packer (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_enable        (w_enable),
        .i_frame_start   (i_frame_start),
        .i_de            (i_de),
        .i_data          (i_data),
        .o_push          (w_push),
        .o_beat          (w_beat),
        .i_credit_return (w_credit_return),
        .o_overflow      (w_overflow)
    );

    beat_fifo u_fifo (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_push          (w_push),
        .i_beat          (w_beat),
        .i_pop           (w_pop),
        .o_head          (w_head),
        .o_count         (w_count),
        .o_credit_return (w_credit_return)
    );

    // beats out to memory
    s2mm_burst_writer u_writer (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_enable        (w_enable),
        .i_base          (w_base),
        .i_page_bursts   (w_page_bursts),
        .i_head          (w_head),
        .i_count         (w_count),
        .o_pop           (w_pop),
        .o_page_done     (w_page_done),
        .o_m_axi_awaddr  (o_m_axi_awaddr),
        .o_m_axi_awlen   (o_m_axi_awlen),
        .o_m_axi_awsize  (o_m_axi_awsize),
        .o_m_axi_awburst (o_m_axi_awburst),
        .o_m_axi_awvalid (o_m_axi_awvalid),
        .i_m_axi_awready (i_m_axi_awready),
        .o_m_axi_wdata   (o_m_axi_wdata),
        .o_m_axi_wstrb   (o_m_axi_wstrb),
        .o_m_axi_wlast   (o_m_axi_wlast),
        .o_m_axi_wvalid  (o_m_axi_wvalid),
        .i_m_axi_wready  (i_m_axi_wready),
        .i_m_axi_bresp   (i_m_axi_bresp),
        .i_m_axi_bvalid  (i_m_axi_bvalid),
        .o_m_axi_bready  (o_m_axi_bready)
    );

endmodule

`default_nettype wire

//--- src/dma_csr.sv
`default_nettype none

module dma_csr (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_csr_we,
    input  dma_pkg::csr_idx_e    i_csr_addr,
    input  dma_pkg::csr_word_t   i_csr_wdata,
    output dma_pkg::csr_word_t   o_csr_rdata,
    output logic                 o_enable,
    output dma_pkg::addr_t       o_base,
    output dma_pkg::burst_cnt_t  o_page_bursts,
    input  logic                 i_overflow,
    input  logic                 i_page_done,
    output logic                 o_irq
);
    import dma_pkg::*;

    // pages sit on 1 KiB boundaries
    localparam addr_t BASE_ALIGN_MASK = ~addr_t'(1023);

    logic       r_enable;
    addr_t      r_base;
    burst_cnt_t r_page;
    logic       r_ovf;
    logic       r_done;
    logic       w_status_wr;

    assign w_status_wr = i_csr_we && (i_csr_addr == CSR_STATUS);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_enable <= 1'b0;
            r_base   <= '0;
            r_page   <= '0;
        end else if (i_csr_we) begin
            case (i_csr_addr)
                CSR_CTRL: r_enable <= i_csr_wdata[0];
                CSR_BASE: r_base   <= addr_t'(i_csr_wdata) & BASE_ALIGN_MASK;
                CSR_PAGE: r_page   <= burst_cnt_t'(i_csr_wdata);
                default:  ;
            endcase
        end
    end

    // sticky flags, datapath set beats host clear
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_ovf  <= 1'b0;
            r_done <= 1'b0;
        end else begin
            if (i_overflow)
                r_ovf <= 1'b1;
            else if (w_status_wr && i_csr_wdata[0])
                r_ovf <= 1'b0;

            if (i_page_done)
                r_done <= 1'b1;
            else if (w_status_wr && i_csr_wdata[1])
                r_done <= 1'b0;
        end
    end

    always_comb begin
        case (i_csr_addr)
            CSR_CTRL:   o_csr_rdata = csr_word_t'(r_enable);
            CSR_BASE:   o_csr_rdata = csr_word_t'(r_base);
            CSR_PAGE:   o_csr_rdata = csr_word_t'(r_page);
            CSR_STATUS: o_csr_rdata = csr_word_t'({r_done, r_ovf});
            default:    o_csr_rdata = '0;
        endcase
    end

    assign o_enable      = r_enable;
    assign o_base        = r_base;
    // zero length behaves as one burst
    assign o_page_bursts = (r_page == '0) ? burst_cnt_t'(1) : r_page;
    assign o_irq         = r_done;

endmodule

`default_nettype wire

//--- tb/dma_sva.sv
`default_nettype none

`include "dma_defines.svh"

module dma_sva (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_awvalid,
    input  logic            i_awready,
    input  dma_pkg::addr_t  i_awaddr,
    input  logic [7:0]      i_awlen,
    input  logic            i_wvalid,
    input  logic            i_wready,
    input  dma_pkg::beat_t  i_wdata,
    input  logic            i_wlast
);
    localparam logic [2:0] LAST_BEAT = 3'(`DMA_BURST_LEN - 1);

    logic [2:0] r_beats;
    logic       r_aw_open;

    // W beats of the open burst, and whether its AW went through
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_beats   <= '0;
            r_aw_open <= 1'b0;
        end else begin
            if (i_awvalid && i_awready)
                r_aw_open <= 1'b1;
            if (i_wvalid && i_wready) begin
                if (i_wlast) begin
                    r_beats   <= '0;
                    r_aw_open <= 1'b0;
                end else begin
                    r_beats <= r_beats + 3'd1;
                end
            end
        end
    end

    //////////////////////////////
    // write channel rules
    //////////////////////////////

    aw_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr) && $stable(i_awlen))
        else $error("AW valid or payload changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wlast))
        else $error("W valid or payload changed before wready");

    // wlast exactly on the fourth beat
    wlast_place: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wvalid |-> (i_wlast == (r_beats == LAST_BEAT)))
        else $error("wlast not on the last beat of the burst");

    w_after_aw: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wvalid |-> r_aw_open)
        else $error("W beat offered before the AW handshake");

endmodule

bind s2mm_burst_writer dma_sva u_sva (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (o_m_axi_awvalid),
    .i_awready (i_m_axi_awready),
    .i_awaddr  (o_m_axi_awaddr),
    .i_awlen   (o_m_axi_awlen),
    .i_wvalid  (o_m_axi_wvalid),
    .i_wready  (i_m_axi_wready),
    .i_wdata   (o_m_axi_wdata),
    .i_wlast   (o_m_axi_wlast)
);

`default_nettype wire

//--- tb/tb_audio_dma.sv
`default_nettype none

`include "dma_defines.svh"

module tb_audio_dma;
    import dma_pkg::*;

    localparam int WAIT_LIMIT  = 2000;
    localparam int BEAT_BYTES  = `DMA_AXI_W / 8;
    localparam int BURST_BYTES = BEAT_BYTES * `DMA_BURST_LEN;

    logic                    clk;
    logic                    i_rst_n;
    logic                    i_frame_start;
    logic                    i_de;
    in_word_t                i_data;
    logic                    i_csr_we;
    csr_idx_e                i_csr_addr;
    csr_word_t               i_csr_wdata;
    csr_word_t               o_csr_rdata;
    logic                    o_irq;
    addr_t                   o_m_axi_awaddr;
    logic [7:0]              o_m_axi_awlen;
    logic [2:0]              o_m_axi_awsize;
    logic [1:0]              o_m_axi_awburst;
    logic                    o_m_axi_awvalid;
    logic                    i_m_axi_awready;
    beat_t                   o_m_axi_wdata;
    logic [`DMA_AXI_W/8-1:0] o_m_axi_wstrb;
    logic                    o_m_axi_wlast;
    logic                    o_m_axi_wvalid;
    logic                    i_m_axi_wready;
    logic [1:0]              i_m_axi_bresp;
    logic                    i_m_axi_bvalid;
    logic                    o_m_axi_bready;

    // slave model, written only by the monitor
    beat_t       mem [addr_t];
    addr_t       aw_q [$];
    logic [44:0] aw_log [$];
    int          w_beat;
    int          b_pending;
    int          b_count;
    int          orphan_beats;

    logic        wready_hold;
    logic [31:0] slave_rng;
    logic [31:0] stim_rng;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    audio_dma_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // tag in the second byte keeps the words of each test apart
    function automatic in_word_t sensor_word(input int tag, input int idx);
        return {8'hA5, 8'(tag), 16'h0000, 32'(idx)};
    endfunction

    // beat n holds words 4n..4n+3, lane 0 lowest
    function automatic beat_t ref_beat(input int tag, input int n);
        beat_t beat;
        int    lane;
        for (lane = 0; lane < `DMA_LANES; lane++)
            beat[lane*`DMA_IN_W +: `DMA_IN_W] = sensor_word(tag, `DMA_LANES * n + lane);
        return beat;
    endfunction

    ////////////////////////////////
    // AXI slave model
    ////////////////////////////////

    initial begin
        slave_rng       = 32'd47673;
        i_m_axi_awready = 1'b0;
        i_m_axi_wready  = 1'b0;
        i_m_axi_bvalid  = 1'b0;
        i_m_axi_bresp   = 2'b00;
        forever begin
            @(negedge clk);
            slave_rng       = lcg(slave_rng);
            i_m_axi_awready = slave_rng[16] | slave_rng[17];
            i_m_axi_wready  = !wready_hold && (slave_rng[18] | slave_rng[19]);
            // bvalid stays up until its handshake
            if (b_pending == 0)
                i_m_axi_bvalid = 1'b0;
            else if (!i_m_axi_bvalid)
                i_m_axi_bvalid = slave_rng[20];
        end
    end

    always @(posedge clk) begin
        if (!i_rst_n) begin
            mem.delete();
            aw_q.delete();
            aw_log.delete();
            w_beat       = 0;
            b_pending    = 0;
            b_count      = 0;
            orphan_beats = 0;
        end else begin
            if (o_m_axi_awvalid && i_m_axi_awready) begin
                aw_q.push_back(o_m_axi_awaddr);
                aw_log.push_back({o_m_axi_awburst, o_m_axi_awsize, o_m_axi_awlen,
                                  o_m_axi_awaddr});
            end
            if (o_m_axi_wvalid && i_m_axi_wready) begin
                // every byte lane of a beat is written
                if (o_m_axi_wstrb !== {BEAT_BYTES{1'b1}})
                    report_mismatch("o_m_axi_wstrb", beat_t'(o_m_axi_wstrb),
                                    beat_t'({BEAT_BYTES{1'b1}}));
                if (aw_q.size() == 0) begin
                    orphan_beats++;
                end else begin
                    mem[aw_q[0] + addr_t'(BEAT_BYTES * w_beat)] = o_m_axi_wdata;
                    w_beat++;
                    if (o_m_axi_wlast) begin
                        void'(aw_q.pop_front());
                        w_beat = 0;
                        b_pending++;
                    end
                end
            end
            if (i_m_axi_bvalid && o_m_axi_bready) begin
                b_pending--;
                b_count++;
            end
        end
    end

    ////////////////////////////////
    // helpers
    ////////////////////////////////

    task automatic report_mismatch(input string name, input beat_t got, input beat_t exp);
        $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic abort_run(input string why);
        $display("%s at t=%0t", why, $time);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic reset_dut();
        i_rst_n     = 1'b0;
        wready_hold = 1'b0;
        repeat (4) @(negedge clk);
        i_rst_n = 1'b1;
        errors_at_start = errors;
    endtask

    task automatic csr_write(input csr_idx_e idx, input csr_word_t value);
        i_csr_we    = 1'b1;
        i_csr_addr  = idx;
        i_csr_wdata = value;
        @(negedge clk);
        i_csr_we = 1'b0;
    endtask

    task automatic csr_read(input csr_idx_e idx, output csr_word_t value);
        i_csr_addr = idx;
        @(negedge clk);
        value = o_csr_rdata;
    endtask

    task automatic setup_page(input addr_t base, input int page, input logic enable);
        csr_write(CSR_BASE, csr_word_t'(base));
        csr_write(CSR_PAGE, csr_word_t'(page));
        csr_write(CSR_CTRL, csr_word_t'(enable));
    endtask

    // one word per data-enable, optional random idle cycles before each
    task automatic feed_words(input int tag, input int count, input logic gaps);
        int k;
        int idle;
        for (k = 0; k < count; k++) begin
            if (gaps) begin
                stim_rng = lcg(stim_rng);
                idle     = int'(stim_rng[17:16]);
                repeat (idle) @(negedge clk);
            end
            i_de   = 1'b1;
            i_data = sensor_word(tag, k);
            @(negedge clk);
            i_de = 1'b0;
        end
    endtask

    task automatic wait_responses(input int n);
        int cycles;
        cycles = 0;
        while (b_count < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                abort_run($sformatf("timeout while waiting for %0d write responses", n));
        end
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (o_irq !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                abort_run("timeout while waiting for the page interrupt");
        end
    endtask

    task automatic compare_memory(input int tag, input addr_t base, input int beats);
        addr_t addr;
        int    n;
        for (n = 0; n < beats; n++) begin
            addr = base + addr_t'(BEAT_BYTES * n);
            if (!mem.exists(addr)) begin
                $display("t=%0t no beat was written at address 0x%0h", $time, addr);
                errors++;
            end else if (mem[addr] !== ref_beat(tag, n)) begin
                report_mismatch($sformatf("mem[0x%0h]", addr), mem[addr], ref_beat(tag, n));
            end
        end
        if (mem.size() != beats)
            report_mismatch("beats in memory", beat_t'(mem.size()), beat_t'(beats));
    endtask

    // burst k of a page at base + k*128, fixed length, size and type
    task automatic check_bursts(input addr_t base, input int page, input int count);
        addr_t exp_addr;
        int    i;
        if (orphan_beats != 0) begin
            $display("t=%0t %0d W beats arrived with no open burst", $time, orphan_beats);
            errors++;
        end
        if (aw_log.size() != count)
            report_mismatch("AW transfers", beat_t'(aw_log.size()), beat_t'(count));
        for (i = 0; i < aw_log.size(); i++) begin
            exp_addr = base + addr_t'(BURST_BYTES * (i % page));
            if (aw_log[i][31:0] !== exp_addr)
                report_mismatch($sformatf("o_m_axi_awaddr[%0d]", i),
                                beat_t'(aw_log[i][31:0]), beat_t'(exp_addr));
            if (aw_log[i][44:32] !== {2'd1, 3'd5, 8'd3})
                report_mismatch($sformatf("{awburst,awsize,awlen}[%0d]", i),
                                beat_t'(aw_log[i][44:32]), beat_t'({2'd1, 3'd5, 8'd3}));
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
    endtask

    ////////////////////////////////
    // test sequence
    ////////////////////////////////

    initial begin
        csr_word_t status;
        int        cycles;
        i_rst_n       = 1'b0;
        i_frame_start = 1'b0;
        i_de          = 1'b0;
        i_data        = '0;
        i_csr_we      = 1'b0;
        i_csr_addr    = CSR_CTRL;
        i_csr_wdata   = '0;
        wready_hold   = 1'b0;
        stim_rng      = 32'd47673;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;

        reset_dut();
        if ({o_m_axi_awvalid, o_m_axi_wvalid, o_m_axi_bready, o_irq} !== 4'b0000)
            report_mismatch("{awvalid,wvalid,bready,o_irq} after reset",
                            beat_t'({o_m_axi_awvalid, o_m_axi_wvalid, o_m_axi_bready, o_irq}),
                            beat_t'(0));
        setup_page(32'h1000, 2, 1'b1);
        feed_words(1, 32, 1'b1);
        // first burst of the page raises no interrupt
        wait_responses(1);
        if (o_irq !== 1'b0)
            report_mismatch("o_irq", beat_t'(o_irq), beat_t'(0));
        wait_responses(2);
        compare_memory(1, 32'h1000, 8);
        check_bursts(32'h1000, 2, 2);
        finish_test("packed beats with gaps");

        errors_at_start = errors;
        wait_irq();
        csr_read(CSR_STATUS, status);
        if (status[1] !== 1'b1)
            report_mismatch("STATUS[1]", beat_t'(status[1]), beat_t'(1));
        csr_write(CSR_STATUS, 32'd2);
        if (o_irq !== 1'b0)
            report_mismatch("o_irq", beat_t'(o_irq), beat_t'(0));
        csr_read(CSR_STATUS, status);
        if (status[1] !== 1'b0)
            report_mismatch("STATUS[1]", beat_t'(status[1]), beat_t'(0));
        finish_test("page interrupt and clear");

        // four bursts over a 3-burst page, the last one wraps
        reset_dut();
        setup_page(32'h2400, 3, 1'b1);
        feed_words(2, 64, 1'b1);
        wait_responses(4);
        check_bursts(32'h2400, 3, 4);
        finish_test("burst addresses and page wrap");

        // two stale words, then frame start
        reset_dut();
        setup_page(32'h3000, 1, 1'b1);
        feed_words(9, 2, 1'b0);
        i_frame_start = 1'b1;
        @(negedge clk);
        i_frame_start = 1'b0;
        feed_words(4, 16, 1'b0);
        wait_responses(1);
        compare_memory(4, 32'h3000, 4);
        check_bursts(32'h3000, 1, 1);
        finish_test("frame start drops partial beat");

        reset_dut();
        setup_page(32'h4000, 4, 1'b1);
        wready_hold = 1'b1;
        feed_words(5, 48, 1'b0);
        repeat (4) @(negedge clk);
        if (uut.w_count !== fifo_cnt_t'(8))
            report_mismatch("beat buffer occupancy", beat_t'(uut.w_count), beat_t'(8));
        csr_read(CSR_STATUS, status);
        if (status[0] !== 1'b1)
            report_mismatch("STATUS[0]", beat_t'(status[0]), beat_t'(1));
        wready_hold = 1'b0;
        wait_responses(2);
        repeat (50) @(negedge clk);
        compare_memory(5, 32'h4000, 8);
        check_bursts(32'h4000, 4, 2);
        finish_test("overflow under held wready");

        reset_dut();
        setup_page(32'h5000, 1, 1'b0);
        feed_words(6, 32, 1'b0);
        cycles = 0;
        while (aw_log.size() == 0 && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        compare_memory(6, 32'h5000, 0);
        check_bursts(32'h5000, 1, 0);
        finish_test("disabled path stays quiet");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
